// ==== dcmp_top.f ====
+incdir+hw
hw/dcmp_pkg.sv
hw/dcmp_apb_regs.sv
hw/dcmp_addr_seq.sv
hw/dcmp_split.sv
hw/dcmp_usehint.sv
hw/dcmp_w1_pack.sv
hw/dcmp_top.sv
verif/tb_dcmp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the decompose engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_dcmp_top \
    -f dcmp_top.f -o tb_dcmp_top \
    && ./obj_dir/tb_dcmp_top | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "^No errors$" "$LOG" && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

// ==== verif/tb_dcmp_top.sv ====
/*
 * Testbench for the decompose engine with coefficient and hint memory models.
 * Memory reads return one cycle after the request. Checks run on the falling edge.
 */
`timescale 1ns/1ps
`include "dcmp_cfg.svh"

module tb_dcmp_top;
    import dcmp_pkg::*;

    localparam int Q          = `DCMP_Q;
    localparam int G          = `DCMP_GAMMA2;
    localparam int NUM_WORDS  = `DCMP_NUM_COEFF / 4;
    localparam int MEM_DEPTH  = 1 << `DCMP_ADDR_W;
    localparam int DONE_LIMIT = 200;

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_SRC    = 8'h04;
    localparam logic [7:0] ADDR_DEST   = 8'h08;
    localparam logic [7:0] ADDR_HINT   = 8'h0C;
    localparam logic [7:0] ADDR_STATUS = 8'h10;

    bit          clk;
    logic        reset_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        mem_rd_en;
    addr_t       mem_rd_addr;
    mem_word_t   mem_rd_data = '0;
    logic        mem_wr_en;
    addr_t       mem_wr_addr;
    mem_word_t   mem_wr_data;
    logic [3:0]  z_nez;
    logic        hint_rd_en;
    addr_t       hint_rd_addr;
    logic [3:0]  hint_rd_data = '0;
    logic [63:0] w1;
    logic        w1_valid;
    logic        done;

    mem_word_t   coef_mem [MEM_DEPTH];
    logic [3:0]  hint_mem [MEM_DEPTH];

    // Settings of the run in progress, as the test programmed them
    addr_t       run_src;
    addr_t       run_dest;
    addr_t       run_hint;
    dcmp_mode_t  run_mode;
    int          rd_cnt;
    int          wr_cnt;
    int          w1_cnt;
    logic        in_run;
    logic        rd_pend;
    addr_t       rd_addr_q;
    integer      seed = 32'hf75c_9f1b;
    int          errors = 0;

    dcmp_top UUT (
        .clk            (clk),
        .reset_n        (reset_n),
        .paddr_i        (paddr),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .pwdata_i       (pwdata),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .mem_rd_en_o    (mem_rd_en),
        .mem_rd_addr_o  (mem_rd_addr),
        .mem_rd_data_i  (mem_rd_data),
        .mem_wr_en_o    (mem_wr_en),
        .mem_wr_addr_o  (mem_wr_addr),
        .mem_wr_data_o  (mem_wr_data),
        .z_nez_o        (z_nez),
        .hint_rd_en_o   (hint_rd_en),
        .hint_rd_addr_o (hint_rd_addr),
        .hint_rd_data_i (hint_rd_data),
        .w1_o           (w1),
        .w1_valid_o     (w1_valid),
        .done_o         (done)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Memory models, one cycle read latency, writes land at the edge
    always @(posedge clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= coef_mem[mem_rd_addr];
        end
        if (hint_rd_en) begin
            hint_rd_data <= hint_mem[hint_rd_addr];
        end
        if (mem_wr_en) begin
            coef_mem[mem_wr_addr] <= mem_wr_data;
        end
        rd_pend   <= reset_n && mem_rd_en;
        rd_addr_q <= mem_rd_addr;
    end

    // Per run counts of reads, writes and w1 words
    always @(posedge clk) begin
        if (!reset_n) begin
            rd_cnt <= 0;
            wr_cnt <= 0;
            w1_cnt <= 0;
            in_run <= 1'b0;
        end else if (UUT.start) begin
            rd_cnt <= 0;
            wr_cnt <= 0;
            w1_cnt <= 0;
            in_run <= 1'b1;
        end else begin
            if (mem_rd_en) rd_cnt <= rd_cnt + 1;
            if (mem_wr_en) wr_cnt <= wr_cnt + 1;
            if (w1_valid) w1_cnt <= w1_cnt + 1;
            if (done) in_run <= 1'b0;
        end
    end

    task automatic log_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Centred r0 in (-G, G], with r0 - 1 in the corner case r - r0 = q-1
    function automatic int centred_r0(input int r);
        int r0;
        r0 = r % (2 * G);
        if (r0 > G) r0 = r0 - 2 * G;
        if (r - r0 == Q - 1) r0 = r0 - 1;
        return r0;
    endfunction

    function automatic int ref_r1(input int r);
        int r0;
        int r1;
        r0 = r % (2 * G);
        if (r0 > G) r0 = r0 - 2 * G;
        if (r - r0 == Q - 1) r1 = 0;
        else r1 = (r - r0) / (2 * G);
        return r1;
    endfunction

    function automatic int use_hint(input int r, input logic h);
        int r1;
        r1 = ref_r1(r);
        if (h && centred_r0(r) > 0) r1 = (r1 + 1) % 16;
        else if (h) r1 = (r1 + 15) % 16;
        return r1;
    endfunction

    function automatic mem_word_t exp_r0_word(input addr_t src);
        mem_word_t w;
        int        r0;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            r0 = centred_r0(int'(coef_mem[src][24*i +: 23]));
            if (r0 < 0) r0 = r0 + Q;
            w[24*i +: 24] = 24'(r0);
        end
        return w;
    endfunction

    function automatic logic [3:0] exp_nez(input addr_t src);
        logic [3:0] nz;
        for (int i = 0; i < 4; i++) begin
            nz[i] = (ref_r1(int'(coef_mem[src][24*i +: 23])) != 0);
        end
        return nz;
    endfunction

    // Word k holds source words 4k..4k+3, lowest coefficient in the low nibble
    function automatic logic [63:0] exp_w1(input int k);
        logic [63:0] w;
        addr_t       src;
        addr_t       hadr;
        logic        h;
        w = '0;
        for (int g = 0; g < 4; g++) begin
            src  = addr_t'(run_src + 4 * k + g);
            hadr = addr_t'(run_hint + 4 * k + g);
            for (int i = 0; i < 4; i++) begin
                h = (run_mode == MODE_VERIFY) && hint_mem[hadr][i];
                w[16*g + 4*i +: 4] = 4'(use_hint(int'(coef_mem[src][24*i +: 23]), h));
            end
        end
        return w;
    endfunction

    a_reset: assert property (@(negedge clk) !reset_n |->
        !mem_rd_en && !hint_rd_en && !mem_wr_en && !w1_valid && !done)
        else log_error("control output high during reset");

    a_rd_addr: assert property (@(negedge clk) disable iff (!reset_n)
        mem_rd_en |-> rd_cnt < NUM_WORDS && mem_rd_addr == addr_t'(run_src + rd_cnt))
        else log_error($sformatf("read %0d at address %h", rd_cnt, mem_rd_addr));

    a_rd_use: assert property (@(negedge clk) disable iff (!reset_n)
        rd_pend |-> UUT.grp_valid && UUT.grp_idx == 6'(rd_addr_q - run_src))
        else log_error($sformatf("read data at %h not taken up", rd_addr_q));

    a_hint_addr: assert property (@(negedge clk) disable iff (!reset_n)
        hint_rd_en |-> run_mode == MODE_VERIFY && mem_rd_en &&
            hint_rd_addr == addr_t'(run_hint + rd_cnt))
        else log_error($sformatf("hint read at address %h", hint_rd_addr));

    a_wr_addr: assert property (@(negedge clk) disable iff (!reset_n)
        mem_wr_en |-> run_mode == MODE_SIGN && wr_cnt < NUM_WORDS &&
            mem_wr_addr == addr_t'(run_dest + wr_cnt))
        else log_error($sformatf("write %0d at address %h", wr_cnt, mem_wr_addr));

    a_wr_data: assert property (@(negedge clk) disable iff (!reset_n)
        mem_wr_en |-> mem_wr_data == exp_r0_word(addr_t'(run_src + wr_cnt)))
        else log_error($sformatf("r0 word %0d is %h, expected %h", wr_cnt, mem_wr_data,
            exp_r0_word(addr_t'(run_src + wr_cnt))));

    a_z_nez: assert property (@(negedge clk) disable iff (!reset_n)
        mem_wr_en |-> z_nez == exp_nez(addr_t'(run_src + wr_cnt)))
        else log_error($sformatf("z_nez of word %0d is %b", wr_cnt, z_nez));

    a_verify_quiet: assert property (@(negedge clk) disable iff (!reset_n)
        in_run && run_mode == MODE_VERIFY && rd_cnt > 0 |-> !mem_wr_en && z_nez == 4'b0)
        else log_error("write activity in verify mode");

    a_w1: assert property (@(negedge clk) disable iff (!reset_n)
        w1_valid |-> w1_cnt < NUM_WORDS / 4 && w1 == exp_w1(w1_cnt))
        else log_error($sformatf("w1 word %0d is %h, expected %h", w1_cnt, w1,
            exp_w1(w1_cnt)));

    a_done_counts: assert property (@(negedge clk) disable iff (!reset_n)
        done |-> rd_cnt == NUM_WORDS && w1_cnt == NUM_WORDS / 4 &&
            wr_cnt == (run_mode == MODE_SIGN ? NUM_WORDS : 0))
        else log_error($sformatf("run ended with %0d reads, %0d writes, %0d w1 words",
            rd_cnt, wr_cnt, w1_cnt));

    task automatic fill_memories();
        logic [31:0] rnd;
        mem_word_t   w;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            w = '0;
            for (int i = 0; i < 4; i++) begin
                rnd = $random(seed);
                w[24*i +: 23] = 23'(rnd % Q);
            end
            coef_mem[a] = w;
            rnd = $random(seed);
            hint_mem[a] = rnd[3:0];
        end
    endtask

    // Boundary coefficients with all hint bits set, giving r1 wraps both ways
    task automatic place_edges(input addr_t src, input addr_t hint);
        coef_mem[src] = {1'b0, 23'(Q - 1 - G), 1'b0, 23'(G + 1), 1'b0, 23'(G), 24'd0};
        coef_mem[addr_t'(src + 1)] = {1'b0, 23'(30 * G + 1), 1'b0, 23'(2 * G),
                                      1'b0, 23'(Q - 1), 1'b0, 23'(Q - G)};
        hint_mem[hint] = 4'hF;
        hint_mem[addr_t'(hint + 1)] = 4'hF;
    endtask

    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        assert (pready) else log_error("pready low in access cycle");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input apb_data_t wdata);
        apb_data_t rd;
        logic      err;
        apb_xfer(addr, 1'b1, wdata, rd, err);
        assert (!err) else log_error($sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input apb_data_t exp,
                                  input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_xfer(addr, 1'b0, '0, rd, err);
        assert (err == exp_err)
            else log_error($sformatf("pslverr %0b at %h, expected %0b", err, addr, exp_err));
        if (!exp_err) begin
            assert (rd == exp)
                else log_error($sformatf("read %h at %h, expected %h", rd, addr, exp));
        end
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            errors++;
            $display("Timeout: done_o did not arrive within %0d cycles", limit);
        end
    endtask

    initial begin
        reset_n  = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        run_src  = 14'h0100;
        run_dest = 14'h0800;
        run_hint = 14'h0200;
        run_mode = MODE_SIGN;
        fill_memories();
        place_edges(14'h0100, 14'h0200);
        place_edges(14'h3FE0, 14'h1000);
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        apb_read_check(ADDR_STATUS, 32'h0, 1'b0);
        apb_read_check(ADDR_CTRL, 32'h0, 1'b0);
        apb_write(ADDR_SRC, 32'h0100);
        apb_write(ADDR_DEST, 32'h0800);
        apb_write(ADDR_HINT, 32'h0200);
        apb_read_check(ADDR_SRC, 32'h0100, 1'b0);
        apb_read_check(ADDR_DEST, 32'h0800, 1'b0);
        apb_read_check(ADDR_HINT, 32'h0200, 1'b0);
        apb_read_check(8'h14, 32'h0, 1'b1);
        apb_read_check(8'h40, 32'h0, 1'b1);

        // Sign run, a second start with verify mode in the middle must change nothing
        apb_write(ADDR_CTRL, 32'h1);
        apb_read_check(ADDR_STATUS, 32'h1, 1'b0);
        apb_write(ADDR_CTRL, 32'h3);
        wait_done(DONE_LIMIT);
        apb_read_check(ADDR_STATUS, 32'h2, 1'b0);

        // Verify run with the source window wrapping past the top address
        run_src  = 14'h3FE0;
        run_hint = 14'h1000;
        run_mode = MODE_VERIFY;
        apb_write(ADDR_SRC, 32'h3FE0);
        apb_write(ADDR_HINT, 32'h1000);
        apb_write(ADDR_CTRL, 32'h3);
        apb_read_check(ADDR_CTRL, 32'h2, 1'b0);
        apb_write(ADDR_SRC, 32'h0);
        apb_read_check(ADDR_SRC, 32'h3FE0, 1'b0);
        wait_done(DONE_LIMIT);
        apb_read_check(ADDR_STATUS, 32'h2, 1'b0);

        repeat (4) @(posedge clk);
        $display("Total errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hw/dcmp_top.sv ====
/*
 * Decompose engine top. Memory and hash sides never stall.
 * Pipeline from read request to write is three cycles.
 */
`timescale 1ns/1ps

module dcmp_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [7:0]             paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  dcmp_pkg::apb_data_t    pwdata_i,
    output dcmp_pkg::apb_data_t    prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   mem_rd_en_o,
    output dcmp_pkg::addr_t        mem_rd_addr_o,
    input  dcmp_pkg::mem_word_t    mem_rd_data_i,
    output logic                   mem_wr_en_o,
    output dcmp_pkg::addr_t        mem_wr_addr_o,
    output dcmp_pkg::mem_word_t    mem_wr_data_o,
    output logic [3:0]             z_nez_o,
    output logic                   hint_rd_en_o,
    output dcmp_pkg::addr_t        hint_rd_addr_o,
    input  logic [3:0]             hint_rd_data_i,
    output logic [63:0]            w1_o,
    output logic                   w1_valid_o,
    output logic                   done_o
);
    import dcmp_pkg::*;

    dcmp_mode_t mode;
    addr_t      src_base;
    addr_t      dest_base;
    addr_t      hint_base;
    logic       start;
    logic       grp_valid;
    logic [5:0] grp_idx;
    logic       sp_valid;
    logic [5:0] sp_idx;
    r1_t [3:0]  sp_r1;
    logic [3:0] sp_r0_pos;
    mem_word_t  sp_r0_modq;
    logic       uh_valid;
    r1_t [3:0]  uh_r1;

    dcmp_apb_regs u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .mode_o      (mode),
        .src_base_o  (src_base),
        .dest_base_o (dest_base),
        .hint_base_o (hint_base),
        .start_o     (start),
        .run_done_i  (done_o)
    );

    dcmp_addr_seq u_seq (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start),
        .mode_i         (mode),
        .src_base_i     (src_base),
        .dest_base_i    (dest_base),
        .hint_base_i    (hint_base),
        .mem_rd_en_o    (mem_rd_en_o),
        .mem_rd_addr_o  (mem_rd_addr_o),
        .hint_rd_en_o   (hint_rd_en_o),
        .hint_rd_addr_o (hint_rd_addr_o),
        .grp_valid_o    (grp_valid),
        .grp_idx_o      (grp_idx),
        .run_done_o     (done_o)
    );

    dcmp_split u_split (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_i   (grp_valid),
        .idx_i     (grp_idx),
        .data_i    (mem_rd_data_i),
        .valid_o   (sp_valid),
        .idx_o     (sp_idx),
        .r1_o      (sp_r1),
        .r0_pos_o  (sp_r0_pos),
        .r0_modq_o (sp_r0_modq)
    );

    dcmp_usehint u_usehint (
        .clk           (clk),
        .reset_n       (reset_n),
        .mode_i        (mode),
        .valid_i       (sp_valid),
        .idx_i         (sp_idx),
        .r1_i          (sp_r1),
        .r0_pos_i      (sp_r0_pos),
        .r0_modq_i     (sp_r0_modq),
        .hint_i        (hint_rd_data_i),
        .dest_base_i   (dest_base),
        .valid_o       (uh_valid),
        .r1_o          (uh_r1),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .z_nez_o       (z_nez_o)
    );

    dcmp_w1_pack u_pack (
        .clk        (clk),
        .reset_n    (reset_n),
        .valid_i    (uh_valid),
        .r1_i       (uh_r1),
        .w1_o       (w1_o),
        .w1_valid_o (w1_valid_o)
    );

endmodule

// ==== hw/dcmp_w1_pack.sv ====
/*
 * Packs four groups of four r1 nibbles into one 64-bit w1 word.
 * The first group lands in the low 16 bits. Runs must be a multiple of four groups.
 */
`timescale 1ns/1ps

module dcmp_w1_pack (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  valid_i,
    input  dcmp_pkg::r1_t [3:0]   r1_i,
    output logic [63:0]           w1_o,
    output logic                  w1_valid_o
);
    import dcmp_pkg::*;

    logic [1:0] grp_cnt;
    r1_t [3:0]  grp;

    assign grp = r1_i;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            grp_cnt    <= '0;
            w1_valid_o <= 1'b0;
        end else begin
            // Wraps back to zero as the fourth group goes in
            if (valid_i) begin
                grp_cnt <= grp_cnt + 2'd1;
            end
            w1_valid_o <= valid_i && (grp_cnt == 2'd3);
        end
    end

    // New groups enter at the top and move down
    always_ff @(posedge clk) begin
        if (valid_i) begin
            w1_o <= {grp, w1_o[63:16]};
        end
    end

endmodule

// ==== hw/dcmp_usehint.sv ====
/*
 * UseHint on r1 in verify mode, r0 write-back with z_nez flags in sign mode.
 * Hint data is expected one cycle after the read, the same as the coefficient data.
 */
`timescale 1ns/1ps

module dcmp_usehint (
    input  logic                     clk,
    input  logic                     reset_n,
    input  dcmp_pkg::dcmp_mode_t     mode_i,
    input  logic                     valid_i,
    input  logic [5:0]               idx_i,
    input  dcmp_pkg::r1_t [3:0]      r1_i,
    input  logic [3:0]               r0_pos_i,
    input  dcmp_pkg::mem_word_t      r0_modq_i,
    input  logic [3:0]               hint_i,
    input  dcmp_pkg::addr_t          dest_base_i,
    output logic                     valid_o,
    output dcmp_pkg::r1_t [3:0]      r1_o,
    output logic                     mem_wr_en_o,
    output dcmp_pkg::addr_t          mem_wr_addr_o,
    output dcmp_pkg::mem_word_t      mem_wr_data_o,
    output logic [3:0]               z_nez_o
);
    import dcmp_pkg::*;

    logic       verify;
    logic [3:0] hint_q;
    r1_t [3:0]  r1_fix;
    logic [3:0] nez;

    assign verify = (mode_i == MODE_VERIFY);

    // Hint returns a cycle before the split result is ready
    always_ff @(posedge clk) begin
        hint_q <= hint_i;
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            r1_fix[i] = r1_i[i];
            // Four-bit wrap gives the mod 16 step
            if (verify && hint_q[i]) begin
                r1_fix[i] = r0_pos_i[i] ? r1_i[i] + 4'd1 : r1_i[i] - 4'd1;
            end
            nez[i] = (r1_i[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_o     <= 1'b0;
            mem_wr_en_o <= 1'b0;
            z_nez_o     <= '0;
        end else begin
            valid_o     <= valid_i;
            mem_wr_en_o <= valid_i && !verify;
            z_nez_o     <= verify ? 4'b0000 : nez;
        end
    end

    always_ff @(posedge clk) begin
        r1_o          <= r1_fix;
        mem_wr_addr_o <= dest_base_i + addr_t'(idx_i);
        mem_wr_data_o <= r0_modq_i;
    end

endmodule

// ==== hw/dcmp_split.sv ====
/*
 * Decompose of four coefficients per cycle for GAMMA2 = (q-1)/32.
 * Inputs must be reduced mod q. Corner case r > q-1-GAMMA2 gives r1 = 0, r0 = r.
 */
`timescale 1ns/1ps
`include "dcmp_cfg.svh"

module dcmp_split (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     valid_i,
    input  logic [5:0]               idx_i,
    input  dcmp_pkg::mem_word_t      data_i,
    output logic                     valid_o,
    output logic [5:0]               idx_o,
    output dcmp_pkg::r1_t [3:0]      r1_o,
    output logic [3:0]               r0_pos_o,
    output dcmp_pkg::mem_word_t      r0_modq_o
);
    import dcmp_pkg::*;

    localparam int CORNER_TH = `DCMP_Q - 1 - `DCMP_GAMMA2;

    coeff_t             r_lane [4];
    r1_t                r1_raw [4];
    logic signed [24:0] r0_c [4];
    coeff_t             modq_lane [4];
    logic [3:0]         corner_d;
    r1_t [3:0]          r1_d;
    logic [3:0]         pos_d;
    mem_word_t          modq_d;

    always_comb begin
        modq_d = '0;
        for (int i = 0; i < 4; i++) begin
            r_lane[i] = data_i[24*i +: 23];

            // r1 counts the odd multiples of GAMMA2 that r lies above
            r1_raw[i] = '0;
            for (int j = 0; j < 15; j++) begin
                if (r_lane[i] > (2 * j + 1) * `DCMP_GAMMA2) begin
                    r1_raw[i] = r1_raw[i] + 4'd1;
                end
            end
            corner_d[i] = (r_lane[i] > CORNER_TH);

            r0_c[i] = 25'(r_lane[i]) - 25'(r1_raw[i] * (2 * `DCMP_GAMMA2));

            if (corner_d[i]) begin
                // Centred r0 is r - q here, never positive
                r1_d[i]      = '0;
                pos_d[i]     = 1'b0;
                modq_lane[i] = r_lane[i];
            end else begin
                r1_d[i]  = r1_raw[i];
                pos_d[i] = (r0_c[i] > 0);
                if (r0_c[i] < 0) begin
                    modq_lane[i] = coeff_t'(r0_c[i] + 25'(`DCMP_Q));
                end else begin
                    modq_lane[i] = coeff_t'(r0_c[i]);
                end
            end
            modq_d[24*i +: 24] = {1'b0, modq_lane[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        idx_o     <= idx_i;
        r1_o      <= r1_d;
        r0_pos_o  <= pos_d;
        r0_modq_o <= modq_d;
    end

    // Lanes arrive reduced mod q, and outside the corner r0 lands in (-GAMMA2, GAMMA2]
    for (genvar i = 0; i < 4; i++) begin : gen_lane_chk
        assert property (@(posedge clk) disable iff (!reset_n)
            valid_i |-> r_lane[i] < `DCMP_Q && (corner_d[i] ||
                (r0_c[i] > -`DCMP_GAMMA2 && r0_c[i] <= `DCMP_GAMMA2)))
            else $error("lane %0d outside the decompose range", i);
    end

endmodule

// ==== hw/dcmp_addr_seq.sv ====
/*
 * Read sequencer for one polynomial, one memory word per cycle.
 * Hint reads run only in verify mode. The drain length matches the pipeline depth.
 */
`timescale 1ns/1ps
`include "dcmp_cfg.svh"

module dcmp_addr_seq (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start_i,
    input  dcmp_pkg::dcmp_mode_t   mode_i,
    input  dcmp_pkg::addr_t        src_base_i,
    input  dcmp_pkg::addr_t        dest_base_i,
    input  dcmp_pkg::addr_t        hint_base_i,
    output logic                   mem_rd_en_o,
    output dcmp_pkg::addr_t        mem_rd_addr_o,
    output logic                   hint_rd_en_o,
    output dcmp_pkg::addr_t        hint_rd_addr_o,
    output logic                   grp_valid_o,
    output logic [5:0]             grp_idx_o,
    output logic                   run_done_o
);
    import dcmp_pkg::*;

    localparam int LAST_WORD    = `DCMP_NUM_COEFF / 4 - 1;
    // Split, hint and pack stages plus the memory return cycle
    localparam int DRAIN_CYCLES = 4;

    seq_state_t state;
    logic [5:0] cnt;
    logic       reading;

    assign reading        = (state == SEQ_READ);
    assign mem_rd_en_o    = reading;
    assign mem_rd_addr_o  = src_base_i + addr_t'(cnt);
    assign hint_rd_en_o   = reading && (mode_i == MODE_VERIFY);
    assign hint_rd_addr_o = hint_base_i + addr_t'(cnt);
    assign run_done_o     = (state == SEQ_DONE);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= SEQ_IDLE;
            cnt         <= '0;
            grp_valid_o <= 1'b0;
        end else begin
            // Valid lines up with the read data, one cycle after the request
            grp_valid_o <= reading;
            case (state)
                SEQ_IDLE: begin
                    if (start_i) begin
                        state <= SEQ_READ;
                        cnt   <= '0;
                    end
                end
                SEQ_READ: begin
                    // Wraps to zero on the last word, ready to count the drain
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'(LAST_WORD)) begin
                        state <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'(DRAIN_CYCLES - 1)) begin
                        state <= SEQ_DONE;
                    end
                end
                SEQ_DONE: state <= SEQ_IDLE;
                default:  state <= SEQ_IDLE;
            endcase
        end
    end

    // Word index follows the data down the pipe
    always_ff @(posedge clk) begin
        grp_idx_o <= cnt;
    end

    // A start only ever reaches an idle sequencer
    assert property (@(posedge clk) disable iff (!reset_n)
        start_i |-> state == SEQ_IDLE)
        else $error("start while the sequencer is running");

endmodule

// ==== hw/dcmp_apb_regs.sv ====
/*
 * APB configuration block. pready_o is tied high, there are no wait states.
 * Start, mode and base writes are dropped while a run is busy.
 */
`timescale 1ns/1ps

module dcmp_apb_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [7:0]             paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  dcmp_pkg::apb_data_t    pwdata_i,
    output dcmp_pkg::apb_data_t    prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output dcmp_pkg::dcmp_mode_t   mode_o,
    output dcmp_pkg::addr_t        src_base_o,
    output dcmp_pkg::addr_t        dest_base_o,
    output dcmp_pkg::addr_t        hint_base_o,
    output logic                   start_o,
    input  logic                   run_done_i
);
    import dcmp_pkg::*;

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_SRC    = 8'h04;
    localparam logic [7:0] ADDR_DEST   = 8'h08;
    localparam logic [7:0] ADDR_HINT   = 8'h0C;
    localparam logic [7:0] ADDR_STATUS = 8'h10;

    logic access;
    logic wr_en;
    logic mapped;
    logic busy_q;
    logic done_q;

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;
    assign mapped = (paddr_i == ADDR_CTRL) || (paddr_i == ADDR_SRC) ||
                    (paddr_i == ADDR_DEST) || (paddr_i == ADDR_HINT) ||
                    (paddr_i == ADDR_STATUS);

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;

    // Start is taken in the access cycle itself
    assign start_o = wr_en && (paddr_i == ADDR_CTRL) && pwdata_i[0] && !busy_q;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            mode_o      <= MODE_SIGN;
            src_base_o  <= '0;
            dest_base_o <= '0;
            hint_base_o <= '0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            if (wr_en && !busy_q) begin
                case (paddr_i)
                    ADDR_CTRL: mode_o      <= dcmp_mode_t'(pwdata_i[1]);
                    ADDR_SRC:  src_base_o  <= addr_t'(pwdata_i);
                    ADDR_DEST: dest_base_o <= addr_t'(pwdata_i);
                    ADDR_HINT: hint_base_o <= addr_t'(pwdata_i);
                    default:   ;
                endcase
            end
            // Done stays set until the next accepted start
            if (start_o) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (run_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (paddr_i)
            ADDR_CTRL:   prdata_o = apb_data_t'({mode_o, 1'b0});
            ADDR_SRC:    prdata_o = apb_data_t'(src_base_o);
            ADDR_DEST:   prdata_o = apb_data_t'(dest_base_o);
            ADDR_HINT:   prdata_o = apb_data_t'(hint_base_o);
            ADDR_STATUS: prdata_o = apb_data_t'({done_q, busy_q});
            default:     prdata_o = '0;
        endcase
    end

    // The sequencer only finishes a run that was started here
    assert property (@(posedge clk) disable iff (!reset_n)
        run_done_i |-> busy_q)
        else $error("run done without a run in progress");

endmodule

// ==== hw/dcmp_pkg.sv ====
/*
 * Shared types of the decompose engine.
 * A memory word holds four 23-bit coefficients in 24-bit slots, top bit zero.
 */
`include "dcmp_cfg.svh"

package dcmp_pkg;

    typedef logic [22:0] coeff_t;

    typedef logic [95:0] mem_word_t;

    typedef logic [3:0] r1_t;

    typedef logic [`DCMP_ADDR_W-1:0] addr_t;

    typedef logic [31:0] apb_data_t;

    typedef enum logic {
        MODE_SIGN   = 1'b0,
        MODE_VERIFY = 1'b1
    } dcmp_mode_t;

    // Address sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_READ  = 2'd1,
        SEQ_DRAIN = 2'd2,
        SEQ_DONE  = 2'd3
    } seq_state_t;

endpackage

// ==== hw/dcmp_cfg.svh ====
/*
 * Build constants for the ML-DSA decompose engine.
 * Only GAMMA2 = (q-1)/32 is supported, so r1 always fits in four bits.
 */
`ifndef DCMP_CFG_SVH
`define DCMP_CFG_SVH

// ML-DSA modulus
`define DCMP_Q          8380417

// (q-1)/32, the only GAMMA2 handled here
`define DCMP_GAMMA2     261888

// Word address width of the coefficient and hint memories
`define DCMP_ADDR_W     14

// One polynomial per run, four coefficients per memory word
`define DCMP_NUM_COEFF  256

`endif
